// ==== sd_cmd_macros.svh ====
`ifndef SD_CMD_MACROS_SVH
`define SD_CMD_MACROS_SVH

// register byte offsets
`define SD_ARGUMENT_ADDR   5'h00
`define SD_COMMAND_ADDR    5'h04
`define SD_RESPONSE_ADDR   5'h08
`define SD_INT_STATUS_ADDR 5'h0C
`define SD_INT_ENABLE_ADDR 5'h10
`define SD_CLOCK_DIV_ADDR  5'h14
`define SD_PRESENT_ADDR    5'h18

// field widths
`define SD_ADDR_W          5
`define SD_DIV_W           8
`define SD_INDEX_W         6
`define SD_FRAME_BITS      48

// card clocks to wait for a response start bit
`define SD_RESP_TIMEOUT    64

// interrupt status bits
`define SD_INT_CC          0
`define SD_INT_CTO         1
`define SD_INT_CCRC        2
`define SD_INT_CIDX        3
`define SD_INT_W           4

`endif

// ==== sd_cmd_pkg.sv ====
`include "sd_cmd_macros.svh"

package sd_cmd_pkg;

    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [`SD_ADDR_W-1:0]  addr;
        logic [31:0]            wdata;
    } reg_req_t;

    typedef struct packed {
        logic [`SD_INDEX_W-1:0] index;
        logic                   resp_en;
        logic                   check_crc;
        logic                   check_index;
        logic [31:0]            argument;
    } cmd_cfg_t;

    // frame body between the two leading bits and the end bit
    typedef struct packed {
        logic [`SD_INDEX_W-1:0] index;
        logic [31:0]            argument;
        logic [6:0]             crc;
    } cmd_frame_t;

    typedef struct packed {
        logic [`SD_INDEX_W-1:0] index;
        logic [31:0]            status;
        logic [6:0]             crc;
    } resp_frame_t;

    typedef struct packed {
        logic                   done;
        logic                   timeout;
        logic                   crc_err;
        logic                   index_err;
        logic [31:0]            status;
    } cmd_event_t;

    // crc7 with x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb     = data[i] ^ crc[6];
            crc    = {crc[5:0], fb};
            crc[3] = crc[3] ^ fb;
        end
        return crc;
    endfunction

endpackage

// ==== sd_reg_bank.sv ====
`timescale 1ns/1ns
`include "sd_cmd_macros.svh"

module sd_reg_bank import sd_cmd_pkg::*; (
    input  logic                 aclk_i,
    input  logic                 arst_n_i,
    input  reg_req_t             reg_req_i,
    output logic [31:0]          rdata_o,
    output logic [`SD_DIV_W-1:0] divisor_o,
    output logic                 cmd_start_o,
    output cmd_cfg_t             cmd_cfg_o,
    input  logic                 cmd_busy_i,
    input  cmd_event_t           cmd_evt_i,
    output logic                 interrupt_o
);
    logic [31:0]                 argument_q;
    logic [8+`SD_INDEX_W-1:0]    command_q;
    logic [31:0]                 response_q;
    logic [`SD_INT_W-1:0]        int_status_q;
    logic [`SD_INT_W-1:0]        int_enable_q;
    logic [`SD_DIV_W-1:0]        divisor_q;
    logic [`SD_INT_W-1:0]        int_set;
    logic [`SD_INT_W-1:0]        int_clr;
    logic [31:0]                 rd_data;

    // command word: resp type [1:0], crc check [3], index check [4], index above bit 8
    assign cmd_cfg_o.index       = command_q[8 +: `SD_INDEX_W];
    assign cmd_cfg_o.resp_en     = |command_q[1:0];
    assign cmd_cfg_o.check_crc   = command_q[3];
    assign cmd_cfg_o.check_index = command_q[4];
    assign cmd_cfg_o.argument    = argument_q;
    assign divisor_o             = divisor_q;

    always_comb begin
        int_set              = '0;
        int_set[`SD_INT_CC]   = cmd_evt_i.done;
        int_set[`SD_INT_CTO]  = cmd_evt_i.done & cmd_evt_i.timeout;
        int_set[`SD_INT_CCRC] = cmd_evt_i.done & cmd_evt_i.crc_err;
        int_set[`SD_INT_CIDX] = cmd_evt_i.done & cmd_evt_i.index_err;
    end

    // write 1 to clear
    assign int_clr = (reg_req_i.wr && reg_req_i.addr == `SD_INT_STATUS_ADDR) ?
                     reg_req_i.wdata[`SD_INT_W-1:0] : '0;

    always_comb begin
        case (reg_req_i.addr)
            `SD_ARGUMENT_ADDR:   rd_data = argument_q;
            `SD_COMMAND_ADDR:    rd_data = 32'(command_q);
            `SD_RESPONSE_ADDR:   rd_data = response_q;
            `SD_INT_STATUS_ADDR: rd_data = 32'(int_status_q);
            `SD_INT_ENABLE_ADDR: rd_data = 32'(int_enable_q);
            `SD_CLOCK_DIV_ADDR:  rd_data = 32'(divisor_q);
            `SD_PRESENT_ADDR:    rd_data = {31'd0, cmd_busy_i};
            default:             rd_data = '0;
        endcase
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            argument_q   <= '0;
            command_q    <= '0;
            response_q   <= '0;
            int_status_q <= '0;
            int_enable_q <= '0;
            divisor_q    <= `SD_DIV_W'(1);
            cmd_start_o  <= 1'b0;
            interrupt_o  <= 1'b0;
            rdata_o      <= '0;
        end else begin
            cmd_start_o <= 1'b0;
            if (reg_req_i.wr) begin
                case (reg_req_i.addr)
                    `SD_ARGUMENT_ADDR:   argument_q <= reg_req_i.wdata;
                    `SD_COMMAND_ADDR: begin
                        command_q   <= reg_req_i.wdata[8+`SD_INDEX_W-1:0];
                        // inhibit also covers the cycle before busy rises
                        cmd_start_o <= !cmd_busy_i && !cmd_start_o;
                    end
                    `SD_INT_ENABLE_ADDR: int_enable_q <= reg_req_i.wdata[`SD_INT_W-1:0];
                    `SD_CLOCK_DIV_ADDR:  divisor_q <= reg_req_i.wdata[`SD_DIV_W-1:0];
                    default: ;
                endcase
            end
            // a new event wins over a clear in the same cycle
            int_status_q <= (int_status_q & ~int_clr) | int_set;
            if (cmd_evt_i.done) begin
                response_q <= cmd_evt_i.status;
            end
            interrupt_o <= |(int_status_q & int_enable_q);
            if (reg_req_i.rd) begin
                rdata_o <= rd_data;
            end
        end
    end

endmodule

// ==== sd_clock_divider.sv ====
`timescale 1ns/1ns
`include "sd_cmd_macros.svh"

module sd_clock_divider (
    input  logic                 aclk_i,
    input  logic                 arst_n_i,
    input  logic [`SD_DIV_W-1:0] divisor_i,
    output logic                 sd_clk_o,
    output logic                 drive_stb_o,
    output logic                 sample_stb_o
);
    logic [`SD_DIV_W-1:0] cnt_q;
    logic                 toggle;

    // >= so a smaller divisor still ends the current half period
    assign toggle = (cnt_q >= divisor_i);

    // strobes sit in the cycle that ends with the card clock edge
    assign drive_stb_o  = toggle & sd_clk_o;
    assign sample_stb_o = toggle & ~sd_clk_o;

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q    <= '0;
            sd_clk_o <= 1'b0;
        end else if (toggle) begin
            cnt_q    <= '0;
            sd_clk_o <= ~sd_clk_o;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

// ==== sd_cmd_master.sv ====
`timescale 1ns/1ns

module sd_cmd_master import sd_cmd_pkg::*; (
    input  logic        aclk_i,
    input  logic        arst_n_i,
    input  logic        cmd_start_i,
    input  cmd_cfg_t    cmd_cfg_i,
    output logic        cmd_busy_o,
    output cmd_event_t  cmd_evt_o,
    output logic        tx_start_o,
    output cmd_frame_t  tx_frame_o,
    output logic        resp_en_o,
    input  logic        rx_done_i,
    input  logic        rx_timeout_i,
    input  resp_frame_t rx_resp_i
);
    cmd_cfg_t cfg_q;
    logic     busy_q;
    logic     got_resp;
    logic     crc_bad;
    logic     idx_bad;

    // crc covers start 0, transmit 1, index and argument
    assign tx_frame_o.index    = cfg_q.index;
    assign tx_frame_o.argument = cfg_q.argument;
    assign tx_frame_o.crc      = crc7({2'b01, cfg_q.index, cfg_q.argument});
    assign resp_en_o           = cfg_q.resp_en;
    assign cmd_busy_o          = busy_q;

    // card response carries a transmit bit of 0
    assign got_resp = cfg_q.resp_en && !rx_timeout_i;
    assign crc_bad  = crc7({2'b00, rx_resp_i.index, rx_resp_i.status}) != rx_resp_i.crc;
    assign idx_bad  = rx_resp_i.index != cfg_q.index;

    always_ff @(posedge aclk_i) begin
        if (cmd_start_i && !busy_q) begin
            cfg_q <= cmd_cfg_i;
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            tx_start_o <= 1'b0;
            cmd_evt_o  <= '0;
        end else begin
            tx_start_o     <= cmd_start_i && !busy_q;
            cmd_evt_o.done <= 1'b0;
            if (cmd_start_i && !busy_q) begin
                busy_q <= 1'b1;
            end else if (busy_q && rx_done_i) begin
                busy_q              <= 1'b0;
                cmd_evt_o.done      <= 1'b1;
                cmd_evt_o.timeout   <= rx_timeout_i;
                cmd_evt_o.crc_err   <= got_resp && cfg_q.check_crc && crc_bad;
                cmd_evt_o.index_err <= got_resp && cfg_q.check_index && idx_bad;
                cmd_evt_o.status    <= got_resp ? rx_resp_i.status : '0;
            end
        end
    end

endmodule

// ==== sd_cmd_serial_host.sv ====
`timescale 1ns/1ns
`include "sd_cmd_macros.svh"

module sd_cmd_serial_host import sd_cmd_pkg::*; (
    input  logic        aclk_i,
    input  logic        arst_n_i,
    input  logic        drive_stb_i,
    input  logic        sample_stb_i,
    input  logic        tx_start_i,
    input  cmd_frame_t  tx_frame_i,
    input  logic        resp_en_i,
    output logic        rx_done_o,
    output logic        rx_timeout_o,
    output resp_frame_t rx_resp_o,
    input  logic        sd_cmd_i,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe_o
);
    localparam int         BIT_W   = $clog2(`SD_FRAME_BITS + 1);
    localparam int         TMO_W   = $clog2(`SD_RESP_TIMEOUT);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_SEND = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_RECV = 2'd3;

    logic [1:0]                state_q;
    logic [`SD_FRAME_BITS-1:0] shift_q;
    logic [BIT_W-1:0]          bit_cnt_q;
    logic [TMO_W-1:0]          tmo_cnt_q;
    logic                      resp_en_q;

    // drop start, transmit and end bits
    assign rx_resp_o = shift_q[`SD_FRAME_BITS-3:1];

    always_ff @(posedge aclk_i) begin
        if (state_q == ST_IDLE && tx_start_i) begin
            shift_q   <= {2'b01, tx_frame_i, 1'b1};
            resp_en_q <= resp_en_i;
        end else if (state_q == ST_SEND && drive_stb_i) begin
            shift_q <= {shift_q[`SD_FRAME_BITS-2:0], 1'b1};
        end else if ((state_q == ST_WAIT || state_q == ST_RECV) && sample_stb_i) begin
            shift_q <= {shift_q[`SD_FRAME_BITS-2:0], sd_cmd_i};
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= ST_IDLE;
            bit_cnt_q    <= '0;
            tmo_cnt_q    <= '0;
            sd_cmd_o     <= 1'b1;
            sd_cmd_oe_o  <= 1'b0;
            rx_done_o    <= 1'b0;
            rx_timeout_o <= 1'b0;
        end else begin
            rx_done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    bit_cnt_q <= '0;
                    if (tx_start_i) state_q <= ST_SEND;
                end
                ST_SEND: if (drive_stb_i) begin
                    // the end bit has held for a full card clock, release the line
                    if (bit_cnt_q == BIT_W'(`SD_FRAME_BITS)) begin
                        sd_cmd_oe_o <= 1'b0;
                        sd_cmd_o    <= 1'b1;
                        tmo_cnt_q   <= '0;
                        state_q     <= resp_en_q ? ST_WAIT : ST_IDLE;
                        rx_done_o    <= !resp_en_q;
                        rx_timeout_o <= 1'b0;
                    end else begin
                        sd_cmd_oe_o <= 1'b1;
                        sd_cmd_o    <= shift_q[`SD_FRAME_BITS-1];
                        bit_cnt_q   <= bit_cnt_q + 1'b1;
                    end
                end
                ST_WAIT: if (sample_stb_i) begin
                    if (!sd_cmd_i) begin
                        bit_cnt_q <= BIT_W'(1);
                        state_q   <= ST_RECV;
                    end else if (tmo_cnt_q == TMO_W'(`SD_RESP_TIMEOUT - 1)) begin
                        rx_done_o    <= 1'b1;
                        rx_timeout_o <= 1'b1;
                        state_q      <= ST_IDLE;
                    end else begin
                        tmo_cnt_q <= tmo_cnt_q + 1'b1;
                    end
                end
                default: if (sample_stb_i) begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == BIT_W'(`SD_FRAME_BITS - 1)) begin
                        rx_done_o    <= 1'b1;
                        rx_timeout_o <= 1'b0;
                        state_q      <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== sd_emmc_controller.sv ====
`timescale 1ns/1ns
`include "sd_cmd_macros.svh"

module sd_emmc_controller import sd_cmd_pkg::*; (
    input  logic        aclk_i,
    input  logic        arst_n_i,
    input  reg_req_t    reg_req_i,
    output logic [31:0] rdata_o,
    output logic        sd_clk_o,
    input  logic        sd_cmd_i,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe_o,
    output logic        interrupt_o
);
    logic [`SD_DIV_W-1:0] divisor;
    logic                 drive_stb;
    logic                 sample_stb;
    logic                 cmd_start;
    cmd_cfg_t             cmd_cfg;
    logic                 cmd_busy;
    cmd_event_t           cmd_evt;
    logic                 tx_start;
    cmd_frame_t           tx_frame;
    logic                 resp_en;
    logic                 rx_done;
    logic                 rx_timeout;
    resp_frame_t          rx_resp;

    sd_reg_bank u_reg_bank (
        .aclk_i, .arst_n_i, .reg_req_i, .rdata_o,
        .divisor_o(divisor), .cmd_start_o(cmd_start), .cmd_cfg_o(cmd_cfg),
        .cmd_busy_i(cmd_busy), .cmd_evt_i(cmd_evt), .interrupt_o
    );

    sd_clock_divider u_clk_div (
        .aclk_i, .arst_n_i, .divisor_i(divisor), .sd_clk_o,
        .drive_stb_o(drive_stb), .sample_stb_o(sample_stb)
    );

    sd_cmd_master u_cmd_master (
        .aclk_i, .arst_n_i, .cmd_start_i(cmd_start), .cmd_cfg_i(cmd_cfg),
        .cmd_busy_o(cmd_busy), .cmd_evt_o(cmd_evt), .tx_start_o(tx_start),
        .tx_frame_o(tx_frame), .resp_en_o(resp_en), .rx_done_i(rx_done),
        .rx_timeout_i(rx_timeout), .rx_resp_i(rx_resp)
    );

    sd_cmd_serial_host u_cmd_host (
        .aclk_i, .arst_n_i, .drive_stb_i(drive_stb), .sample_stb_i(sample_stb),
        .tx_start_i(tx_start), .tx_frame_i(tx_frame), .resp_en_i(resp_en),
        .rx_done_o(rx_done), .rx_timeout_o(rx_timeout), .rx_resp_o(rx_resp),
        .sd_cmd_i, .sd_cmd_o, .sd_cmd_oe_o
    );

endmodule

// ==== sd_cmd_props.sv ====
`timescale 1ns/1ns

module sd_cmd_props (
    input logic aclk_i,
    input logic arst_n_i,
    input logic card_clk_i,
    input logic cmd_line_i,
    input logic cmd_oe_i,
    input logic irq_i,
    input logic cmd_done_i
);

    // a released line rests high
    idle_high: assert property (
        @(posedge aclk_i) disable iff (!arst_n_i)
        !cmd_oe_i |-> cmd_line_i
    ) else $error("sd_cmd_o low while sd_cmd_oe_o is low");

    // the host drives only on falling card clock edges
    drive_on_fall: assert property (
        @(posedge aclk_i) disable iff (!arst_n_i)
        $rose(card_clk_i) |-> $stable(cmd_oe_i) && $stable(cmd_line_i)
    ) else $error("sd_cmd_o or sd_cmd_oe_o changed with a rising sd_clk_o");

    // status bits follow done by one cycle, the interrupt by one more
    irq_after_done: assert property (
        @(posedge aclk_i) disable iff (!arst_n_i)
        $rose(irq_i) |-> $past(cmd_done_i, 1) || $past(cmd_done_i, 2)
    ) else $error("interrupt_o rose without a command completion");

endmodule

bind sd_emmc_controller sd_cmd_props u_props (
    .aclk_i     (aclk_i),
    .arst_n_i   (arst_n_i),
    .card_clk_i (sd_clk_o),
    .cmd_line_i (sd_cmd_o),
    .cmd_oe_i   (sd_cmd_oe_o),
    .irq_i      (interrupt_o),
    .cmd_done_i (cmd_evt.done)
);

// ==== tb_sd_emmc_controller.sv ====
`timescale 1ns/1ns
`include "sd_cmd_macros.svh"

module tb_sd_emmc_controller import sd_cmd_pkg::*; ();

    localparam int NUM_CMDS    = 24;
    localparam int MAX_DIV     = 3;
    localparam int CYCLE_LIMIT = NUM_CMDS * 2 * (`SD_FRAME_BITS * 2 + `SD_RESP_TIMEOUT + 10)
                                 * (MAX_DIV + 1) + 1000;

    logic        aclk;
    logic        arst_n;
    reg_req_t    reg_req;
    logic [31:0] rdata;
    logic        sd_clk;
    logic        sd_cmd_in;
    logic        sd_cmd;
    logic        sd_cmd_oe;
    logic        irq;

    logic [31:0] rng_state;
    int          cyc;
    int          n_checks;
    int          n_errors;
    int          frame_cnt;
    int          done_cnt;

    // what the card model expects and how it answers
    cmd_frame_t  exp_frame;
    logic        card_answers;
    logic [1:0]  resp_kind;
    int          resp_delay;
    logic [31:0] card_status;

    sd_emmc_controller u_dut (
        .aclk_i      (aclk),
        .arst_n_i    (arst_n),
        .reg_req_i   (reg_req),
        .rdata_o     (rdata),
        .sd_clk_o    (sd_clk),
        .sd_cmd_i    (sd_cmd_in),
        .sd_cmd_o    (sd_cmd),
        .sd_cmd_oe_o (sd_cmd_oe),
        .interrupt_o (irq)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #10;
            aclk = ~aclk;
        end
    end

    always @(posedge aclk) begin
        cyc++;
        if (u_dut.cmd_evt.done) begin
            done_cnt++;
        end
        if (cyc > CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d  errors: %0d", n_checks, n_errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_int(input string name, input logic [`SD_INT_W-1:0] got,
                             input logic [`SD_INT_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_frame(input string name, input cmd_frame_t got, input cmd_frame_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // all register tasks start and end 2 ns after a rising edge
    task automatic write_reg(input logic [`SD_ADDR_W-1:0] addr, input logic [31:0] data);
        reg_req.wr    = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        @(posedge aclk);
        #2;
        reg_req.wr = 1'b0;
    endtask

    task automatic read_reg(input logic [`SD_ADDR_W-1:0] addr, output logic [31:0] data);
        reg_req.rd   = 1'b1;
        reg_req.addr = addr;
        @(posedge aclk);
        #2;
        reg_req.rd = 1'b0;
        data = rdata;
    endtask

    task automatic check_reg(input logic [`SD_ADDR_W-1:0] addr, input string name,
                             input logic [31:0] exp);
        logic [31:0] data;
        read_reg(addr, data);
        check_word(name, data, exp);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge aclk);
        #2;
    endtask

    // poll the command inhibit bit
    task automatic wait_idle();
        logic [31:0] present;
        present = 32'h1;
        while (present[0]) begin
            read_reg(`SD_PRESENT_ADDR, present);
        end
    endtask

    task automatic check_clock_period(input logic [`SD_DIV_W-1:0] div);
        int t0;
        write_reg(`SD_CLOCK_DIV_ADDR, {24'd0, div});
        // first edge may still belong to the old divisor
        @(posedge sd_clk);
        @(posedge sd_clk);
        t0 = cyc;
        @(posedge sd_clk);
        check_word("sd_clk_o period", 32'(cyc - t0), 32'(2 * (div + 1)));
        @(posedge aclk);
        #2;
    endtask

    // card: reads frames on rising sd_clk, answers on falling sd_clk
    initial begin : card_model
        logic [`SD_FRAME_BITS-1:0] rx_bits;
        logic [`SD_FRAME_BITS-1:0] tx_bits;
        logic [`SD_INDEX_W-1:0]    r_idx;
        logic [6:0]                r_crc;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe) begin
                rx_bits    = '0;
                rx_bits[0] = sd_cmd;
                for (int i = 1; i < `SD_FRAME_BITS; i++) begin
                    @(posedge sd_clk);
                    rx_bits = {rx_bits[`SD_FRAME_BITS-2:0], sd_cmd};
                end
                frame_cnt++;
                check_bit("frame start bit", rx_bits[47], 1'b0);
                check_bit("frame transmit bit", rx_bits[46], 1'b1);
                check_frame("frame body", cmd_frame_t'(rx_bits[45:1]), exp_frame);
                check_bit("frame end bit", rx_bits[0], 1'b1);
                if (card_answers) begin
                    r_idx = rx_bits[45:40];
                    if (resp_kind == 2'd2) begin
                        r_idx = r_idx ^ 6'h15;
                    end
                    r_crc = crc7({2'b00, r_idx, card_status});
                    if (resp_kind == 2'd1) begin
                        r_crc = r_crc ^ 7'h04;
                    end
                    tx_bits = {2'b00, r_idx, card_status, r_crc, 1'b1};
                    repeat (resp_delay) @(negedge sd_clk);
                    for (int i = `SD_FRAME_BITS - 1; i >= 0; i--) begin
                        @(negedge sd_clk);
                        #2;
                        sd_cmd_in = tx_bits[i];
                    end
                end
            end
        end
    end

    initial begin : main
        logic [31:0]          rd;
        logic [31:0]          rnd;
        logic [31:0]          arg;
        logic [31:0]          exp_resp;
        logic [5:0]           idx;
        logic [1:0]           rtype;
        logic [7:0]           div;
        logic                 chk_crc;
        logic                 chk_idx;
        logic                 busy_write;
        logic [`SD_INT_W-1:0] enable;
        logic [`SD_INT_W-1:0] clr;
        logic [`SD_INT_W-1:0] exp_int;
        int                   frames_before;
        int                   dones_before;

        rng_state    = 32'd42;
        cyc          = 0;
        n_checks     = 0;
        n_errors     = 0;
        frame_cnt    = 0;
        done_cnt     = 0;
        exp_frame    = '0;
        card_answers = 1'b0;
        resp_kind    = 2'd0;
        resp_delay   = 2;
        card_status  = '0;
        reg_req      = '0;
        sd_cmd_in    = 1'b1;
        arst_n       = 1'b0;

        repeat (10) @(posedge aclk);
        check_bit("interrupt_o", irq, 1'b0);
        check_bit("sd_cmd_oe_o", sd_cmd_oe, 1'b0);
        check_bit("sd_clk_o", sd_clk, 1'b0);
        check_bit("sd_cmd_o", sd_cmd, 1'b1);
        #2;
        arst_n = 1'b1;

        check_reg(`SD_ARGUMENT_ADDR, "ARGUMENT", 32'h0);
        check_reg(`SD_COMMAND_ADDR, "COMMAND", 32'h0);
        check_reg(`SD_RESPONSE_ADDR, "RESPONSE", 32'h0);
        check_reg(`SD_INT_STATUS_ADDR, "INT_STATUS", 32'h0);
        check_reg(`SD_INT_ENABLE_ADDR, "INT_ENABLE", 32'h0);
        check_reg(`SD_CLOCK_DIV_ADDR, "CLOCK_DIV", 32'h1);
        check_reg(`SD_PRESENT_ADDR, "PRESENT", 32'h0);

        for (int i = 0; i < 4; i++) begin
            rnd = next_random();
            div = {6'd0, rnd[1:0]};
            check_clock_period(div);
        end

        for (int n = 0; n < NUM_CMDS; n++) begin
            rnd          = next_random();
            idx          = rnd[5:0];
            rtype        = rnd[9:8];
            chk_crc      = rnd[10];
            chk_idx      = rnd[11];
            // 0 good, 1 bad crc, 2 wrong index, 3 silent
            resp_kind    = rnd[13:12];
            resp_delay   = 2 + int'(rnd[19:16]) % 9;
            enable       = rnd[23:20];
            clr          = rnd[27:24];
            div          = {6'd0, rnd[29:28]};
            busy_write   = rnd[30];
            arg          = next_random();
            card_status  = next_random();
            card_answers = (rtype != 2'b00) && (resp_kind != 2'd3);

            exp_frame.index    = idx;
            exp_frame.argument = arg;
            exp_frame.crc      = crc7({2'b01, idx, arg});
            exp_int            = '0;
            exp_int[`SD_INT_CC] = 1'b1;
            exp_resp           = 32'h0;
            if (rtype != 2'b00) begin
                if (resp_kind == 2'd3) begin
                    exp_int[`SD_INT_CTO] = 1'b1;
                end else begin
                    exp_resp = card_status;
                    exp_int[`SD_INT_CCRC] = (resp_kind == 2'd1) && chk_crc;
                    exp_int[`SD_INT_CIDX] = (resp_kind == 2'd2) && chk_idx;
                end
            end

            // enable changes only while the status is clear
            write_reg(`SD_INT_STATUS_ADDR, 32'h0000_000f);
            write_reg(`SD_INT_ENABLE_ADDR, {28'd0, enable});
            write_reg(`SD_CLOCK_DIV_ADDR, {24'd0, div});
            write_reg(`SD_ARGUMENT_ADDR, arg);
            frames_before = frame_cnt;
            dones_before  = done_cnt;
            write_reg(`SD_COMMAND_ADDR, {18'd0, idx, 3'd0, chk_idx, chk_crc, 1'b0, rtype});
            wait_cycles(2);
            check_reg(`SD_PRESENT_ADDR, "PRESENT", 32'h1);
            if (busy_write) begin
                write_reg(`SD_COMMAND_ADDR, {18'd0, ~idx, 3'd0, chk_idx, chk_crc, 1'b0, rtype});
            end
            wait_idle();
            wait_cycles(3);

            check_word("frames on sd_cmd_o", 32'(frame_cnt - frames_before), 32'd1);
            check_word("command completions", 32'(done_cnt - dones_before), 32'd1);
            check_reg(`SD_RESPONSE_ADDR, "RESPONSE", exp_resp);
            read_reg(`SD_INT_STATUS_ADDR, rd);
            check_int("INT_STATUS", rd[`SD_INT_W-1:0], exp_int);
            check_bit("interrupt_o", irq, |(exp_int & enable));

            write_reg(`SD_INT_STATUS_ADDR, {28'd0, clr});
            wait_cycles(2);
            read_reg(`SD_INT_STATUS_ADDR, rd);
            check_int("INT_STATUS after clear", rd[`SD_INT_W-1:0], exp_int & ~clr);
            check_bit("interrupt_o after clear", irq, |(exp_int & ~clr & enable));
        end

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
sd_cmd_pkg.sv
sd_reg_bank.sv
sd_clock_divider.sv
sd_cmd_master.sv
sd_cmd_serial_host.sv
sd_emmc_controller.sv
sd_cmd_props.sv
tb_sd_emmc_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_sd_emmc_controller
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TESTS PASSED$$" $(LOG); then echo "result: pass"; \
	else echo "result: fail"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
